//--- verilog/csr_bridge_macros.svh
// Width and register-count macros shared by the bridge package, RTL and testbench
`ifndef CSR_BRIDGE_MACROS_SVH
`define CSR_BRIDGE_MACROS_SVH

// ---------------------------------------
// Data path
// ---------------------------------------
`define CSR_DATA_W      32  // Read and write data

// ---------------------------------------
// Addressing
// ---------------------------------------
`define CSR_ADDR_W      19  // Host side indirect address
`define CSR_AXI_ADDR_W  19  // AXI4-Lite byte address

// Register bank depth in 32-bit words
`define CSR_NUM_REGS    16

`endif

//--- verilog/csr_bridge_pkg.sv
// Command and AXI4-Lite channel types for the indirect CSR path, imported by each RTL block
`include "csr_bridge_macros.svh"

package csr_bridge_pkg;

   // ---------------------------------------
   // Host command and response codes
   // ---------------------------------------
   typedef enum logic [1:0] {
      NOOP  = 2'd0,
      READ  = 2'd1,
      WRITE = 2'd2
   } csr_cmd_e;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axil_resp_e;

   // ---------------------------------------
   // AXI4-Lite channel payloads
   // ---------------------------------------

   // AW and AR, no prot since the bridge only sends one fixed value
   typedef struct packed {
      logic [`CSR_AXI_ADDR_W-1:0] addr;
   } axil_ax_t;

   // W, always a full word
   typedef struct packed {
      logic [`CSR_DATA_W-1:0] data;
   } axil_w_t;

   typedef struct packed {
      axil_resp_e resp;
   } axil_b_t;

   typedef struct packed {
      logic [`CSR_DATA_W-1:0] data;
      axil_resp_e             resp;
   } axil_r_t;

endpackage

//--- verilog/indirect_csr_master.sv
// Bridge that turns each held indirect CSR command into one AXI4-Lite read or write
`timescale 1ns/1ps
`include "csr_bridge_macros.svh"

module indirect_csr_master (
   input  logic                      i_csr_clk,
   input  logic                      i_csr_rst_n,
   // Host command side
   input  csr_bridge_pkg::csr_cmd_e  i_csr_cmd,
   input  logic [`CSR_ADDR_W-1:0]    i_csr_addr,
   input  logic [`CSR_DATA_W-1:0]    i_csr_writedata,
   output logic [`CSR_DATA_W-1:0]    o_csr_readdata,
   output logic                      o_csr_ack,
   output logic [1:0]                o_csr_rresp,
   output logic [1:0]                o_csr_bresp,
   // AXI4-Lite master channels
   output logic                      o_aw_valid,
   output csr_bridge_pkg::axil_ax_t  o_aw,
   input  logic                      i_aw_ready,
   output logic                      o_w_valid,
   output csr_bridge_pkg::axil_w_t   o_w,
   input  logic                      i_w_ready,
   output logic                      o_ar_valid,
   output csr_bridge_pkg::axil_ax_t  o_ar,
   input  logic                      i_ar_ready,
   input  logic                      i_b_valid,
   input  csr_bridge_pkg::axil_b_t   i_b,
   output logic                      o_b_ready,
   input  logic                      i_r_valid,
   input  csr_bridge_pkg::axil_r_t   i_r,
   output logic                      o_r_ready
);
   import csr_bridge_pkg::*;

   // ---------------------------------------
   // One-hot state encoding
   // ---------------------------------------
   localparam int IDLE_B   = 0;
   localparam int WRITE_B  = 1;
   localparam int READ_B   = 2;
   localparam int WAIT_B_B = 3;
   localparam int WAIT_R_B = 4;
   localparam int ACK_B    = 5;
   localparam int NUM_ST   = 6;

   typedef enum logic [NUM_ST-1:0] {
      ST_IDLE   = 6'b00_0001,
      ST_WRITE  = 6'b00_0010,
      ST_READ   = 6'b00_0100,
      ST_WAIT_B = 6'b00_1000,
      ST_WAIT_R = 6'b01_0000,
      ST_ACK    = 6'b10_0000
   } state_e;

   state_e                  state;
   logic [`CSR_ADDR_W-1:0]  csr_addr;   // Sampled while idle
   logic [`CSR_DATA_W-1:0]  csr_wdata;

   // Fixed full-word requests, responses always taken
   always_comb begin
      o_aw.addr = csr_addr;
      o_ar.addr = csr_addr;
      o_w.data  = csr_wdata;
   end

   assign o_b_ready = 1'b1;
   assign o_r_ready = 1'b1;

   // Address and data follow the host until a command starts
   always_ff @(posedge i_csr_clk) begin
      if (state[IDLE_B]) begin
         csr_addr  <= i_csr_addr;
         csr_wdata <= i_csr_writedata;
      end
   end

   // Last response seen on each return channel
   always_ff @(posedge i_csr_clk) begin
      if (!i_csr_rst_n) begin
         o_csr_readdata <= '0;
         o_csr_rresp    <= '0;
         o_csr_bresp    <= '0;
      end else begin
         if (i_r_valid && o_r_ready) begin
            o_csr_readdata <= i_r.data;
            o_csr_rresp    <= i_r.resp;
         end
         if (i_b_valid && o_b_ready) begin
            o_csr_bresp <= i_b.resp;
         end
      end
   end

   // ---------------------------------------
   // Command FSM
   // ---------------------------------------
   always_ff @(posedge i_csr_clk) begin
      if (!i_csr_rst_n) begin
         state      <= ST_IDLE;
         o_csr_ack  <= 1'b0;
         o_aw_valid <= 1'b0;
         o_w_valid  <= 1'b0;
         o_ar_valid <= 1'b0;
      end else begin
         o_csr_ack <= 1'b0;
         unique case (1'b1)
            state[IDLE_B]: begin
               case (i_csr_cmd)
                  READ:    state <= ST_READ;
                  WRITE:   state <= ST_WRITE;
                  default: state <= ST_IDLE;
               endcase
            end
            state[WRITE_B]: begin
               o_aw_valid <= 1'b1;   // AW and W go out together
               o_w_valid  <= 1'b1;
               state      <= ST_WAIT_B;
            end
            state[READ_B]: begin
               o_ar_valid <= 1'b1;
               state      <= ST_WAIT_R;
            end
            state[WAIT_B_B]: begin
               if (i_aw_ready) begin
                  o_aw_valid <= 1'b0;
               end
               if (i_w_ready) begin
                  o_w_valid <= 1'b0;
               end
               if (i_b_valid) begin
                  state <= ST_ACK;
               end
            end
            state[WAIT_R_B]: begin
               if (i_ar_ready) begin
                  o_ar_valid <= 1'b0;
               end
               if (i_r_valid) begin
                  state <= ST_ACK;
               end
            end
            state[ACK_B]: begin
               o_csr_ack <= 1'b1;
               if (i_csr_cmd == NOOP) begin   // Host has released the command
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   a_state_onehot: assert property (@(posedge i_csr_clk) disable iff (!i_csr_rst_n)
      $onehot(state))
      else $error("bridge state is not one-hot");

   a_aw_hold: assert property (@(posedge i_csr_clk) disable iff (!i_csr_rst_n)
      o_aw_valid && !i_aw_ready |=> o_aw_valid && $stable(o_aw))
      else $error("AW valid or address changed before AW ready");

endmodule

//--- verilog/axil_channel_slice.sv
// Two-entry skid register for one valid/ready channel, payload type chosen per instance
`timescale 1ns/1ps

module axil_channel_slice #(
   parameter type t_payload = logic
) (
   input  logic     i_csr_clk,
   input  logic     i_csr_rst_n,
   // Upstream
   input  logic     i_valid,
   input  t_payload i_data,
   output logic     o_ready,
   // Downstream
   output logic     o_valid,
   output t_payload o_data,
   input  logic     i_ready
);

   logic     spare_valid;
   t_payload spare_data;   // Catches one item while the output stalls
   logic     in_fire;
   logic     main_load;

   assign o_ready   = !spare_valid;           // Low only with both entries full
   assign in_fire   = i_valid && o_ready;
   assign main_load = !o_valid || i_ready;    // Output empty or draining

   // ---------------------------------------
   // Occupancy
   // ---------------------------------------
   always_ff @(posedge i_csr_clk) begin
      if (!i_csr_rst_n) begin
         o_valid     <= 1'b0;
         spare_valid <= 1'b0;
      end else if (main_load) begin
         o_valid     <= spare_valid || in_fire;
         spare_valid <= 1'b0;
      end else if (in_fire) begin
         spare_valid <= 1'b1;
      end
   end

   // Spare entry drains first to keep order
   always_ff @(posedge i_csr_clk) begin
      if (main_load) begin
         o_data <= spare_valid ? spare_data : i_data;
      end else if (in_fire) begin
         spare_data <= i_data;
      end
   end

   a_out_hold: assert property (@(posedge i_csr_clk) disable iff (!i_csr_rst_n)
      o_valid && !i_ready |=> o_valid && $stable(o_data))
      else $error("slice output changed while stalled");

   // An item offered to a full buffer must wait, or it is lost
   a_no_overflow: assert property (@(posedge i_csr_clk) disable iff (!i_csr_rst_n)
      i_valid && !o_ready |=> i_valid && $stable(i_data))
      else $error("slice input dropped or changed while both entries full");

endmodule

//--- verilog/csr_register_file.sv
// AXI4-Lite slave with a bank of 32-bit registers, SLVERR for addresses past the bank
`timescale 1ns/1ps
`include "csr_bridge_macros.svh"

module csr_register_file (
   input  logic                      i_csr_clk,
   input  logic                      i_csr_rst_n,
   // Write address and data
   input  logic                      i_aw_valid,
   input  csr_bridge_pkg::axil_ax_t  i_aw,
   output logic                      o_aw_ready,
   input  logic                      i_w_valid,
   input  csr_bridge_pkg::axil_w_t   i_w,
   output logic                      o_w_ready,
   // Write response
   output logic                      o_b_valid,
   output csr_bridge_pkg::axil_b_t   o_b,
   input  logic                      i_b_ready,
   // Read address and data
   input  logic                      i_ar_valid,
   input  csr_bridge_pkg::axil_ax_t  i_ar,
   output logic                      o_ar_ready,
   output logic                      o_r_valid,
   output csr_bridge_pkg::axil_r_t   o_r,
   input  logic                      i_r_ready
);
   import csr_bridge_pkg::*;

   localparam int IDX_W  = $clog2(`CSR_NUM_REGS);
   localparam int WORD_W = `CSR_AXI_ADDR_W - 2;

   logic [`CSR_DATA_W-1:0] regs [`CSR_NUM_REGS];
   logic                   wr_fire;
   logic                   rd_fire;
   logic                   wr_hit;
   logic                   rd_hit;
   logic [IDX_W-1:0]       wr_idx;
   logic [IDX_W-1:0]       rd_idx;

   // Word address inside the bank
   function automatic logic in_bank(input logic [`CSR_AXI_ADDR_W-1:0] addr);
      logic [WORD_W-1:0] word;
      word = addr[`CSR_AXI_ADDR_W-1:2];
      return (word < `CSR_NUM_REGS);
   endfunction

   // ---------------------------------------
   // Handshake
   // ---------------------------------------
   assign wr_fire    = i_aw_valid && i_w_valid && !o_b_valid;  // AW and W taken together
   assign o_aw_ready = wr_fire;
   assign o_w_ready  = wr_fire;
   assign rd_fire    = i_ar_valid && !o_r_valid;
   assign o_ar_ready = !o_r_valid;             // One read in flight

   assign wr_hit = in_bank(i_aw.addr);
   assign rd_hit = in_bank(i_ar.addr);
   assign wr_idx = i_aw.addr[IDX_W+1:2];
   assign rd_idx = i_ar.addr[IDX_W+1:2];

   // Register bank and response valids
   always_ff @(posedge i_csr_clk) begin
      if (!i_csr_rst_n) begin
         for (int i = 0; i < `CSR_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
         o_b_valid <= 1'b0;
         o_r_valid <= 1'b0;
      end else begin
         if (wr_fire && wr_hit) begin
            regs[wr_idx] <= i_w.data;   // Full-word write
         end
         if (wr_fire) begin
            o_b_valid <= 1'b1;
         end else if (i_b_ready) begin
            o_b_valid <= 1'b0;
         end
         if (rd_fire) begin
            o_r_valid <= 1'b1;
         end else if (i_r_ready) begin
            o_r_valid <= 1'b0;
         end
      end
   end

   // Response payloads, held until the next accepted request
   always_ff @(posedge i_csr_clk) begin
      if (wr_fire) begin
         o_b.resp <= wr_hit ? OKAY : SLVERR;
      end
      if (rd_fire) begin
         o_r.data <= rd_hit ? regs[rd_idx] : '0;   // Zero outside the bank
         o_r.resp <= rd_hit ? OKAY : SLVERR;
      end
   end

   a_b_hold: assert property (@(posedge i_csr_clk) disable iff (!i_csr_rst_n)
      o_b_valid && !i_b_ready |=> o_b_valid && $stable(o_b))
      else $error("B response dropped before B ready");

endmodule

//--- verilog/indirect_csr_top.sv
// Indirect CSR path top joining the bridge, one slice per AXI4-Lite channel and the registers
`timescale 1ns/1ps
`include "csr_bridge_macros.svh"

module indirect_csr_top (
   input  logic                      i_csr_clk,
   input  logic                      i_csr_rst_n,
   input  csr_bridge_pkg::csr_cmd_e  i_csr_cmd,
   input  logic [`CSR_ADDR_W-1:0]    i_csr_addr,
   input  logic [`CSR_DATA_W-1:0]    i_csr_writedata,
   output logic [`CSR_DATA_W-1:0]    o_csr_readdata,
   output logic                      o_csr_ack,
   output logic [1:0]                o_csr_rresp,
   output logic [1:0]                o_csr_bresp
);
   import csr_bridge_pkg::*;

   // ---------------------------------------
   // Channels, m_ at the bridge, s_ at the register file
   // ---------------------------------------
   logic     m_aw_valid, m_aw_ready, s_aw_valid, s_aw_ready;
   axil_ax_t m_aw, s_aw;
   logic     m_w_valid, m_w_ready, s_w_valid, s_w_ready;
   axil_w_t  m_w, s_w;
   logic     m_ar_valid, m_ar_ready, s_ar_valid, s_ar_ready;
   axil_ax_t m_ar, s_ar;
   logic     m_b_valid, m_b_ready, s_b_valid, s_b_ready;
   axil_b_t  m_b, s_b;
   logic     m_r_valid, m_r_ready, s_r_valid, s_r_ready;
   axil_r_t  m_r, s_r;

   indirect_csr_master u_master (
      .i_csr_clk, .i_csr_rst_n,
      .i_csr_cmd, .i_csr_addr, .i_csr_writedata,
      .o_csr_readdata, .o_csr_ack, .o_csr_rresp, .o_csr_bresp,
      .o_aw_valid(m_aw_valid), .o_aw(m_aw), .i_aw_ready(m_aw_ready),
      .o_w_valid(m_w_valid), .o_w(m_w), .i_w_ready(m_w_ready),
      .o_ar_valid(m_ar_valid), .o_ar(m_ar), .i_ar_ready(m_ar_ready),
      .i_b_valid(m_b_valid), .i_b(m_b), .o_b_ready(m_b_ready),
      .i_r_valid(m_r_valid), .i_r(m_r), .o_r_ready(m_r_ready)
   );

   // Request channels toward the register file
   axil_channel_slice #(.t_payload(axil_ax_t)) u_aw_slice (
      .i_csr_clk, .i_csr_rst_n,
      .i_valid(m_aw_valid), .i_data(m_aw), .o_ready(m_aw_ready),
      .o_valid(s_aw_valid), .o_data(s_aw), .i_ready(s_aw_ready)
   );
   axil_channel_slice #(.t_payload(axil_w_t)) u_w_slice (
      .i_csr_clk, .i_csr_rst_n,
      .i_valid(m_w_valid), .i_data(m_w), .o_ready(m_w_ready),
      .o_valid(s_w_valid), .o_data(s_w), .i_ready(s_w_ready)
   );
   axil_channel_slice #(.t_payload(axil_ax_t)) u_ar_slice (
      .i_csr_clk, .i_csr_rst_n,
      .i_valid(m_ar_valid), .i_data(m_ar), .o_ready(m_ar_ready),
      .o_valid(s_ar_valid), .o_data(s_ar), .i_ready(s_ar_ready)
   );

   // Response channels back to the bridge
   axil_channel_slice #(.t_payload(axil_b_t)) u_b_slice (
      .i_csr_clk, .i_csr_rst_n,
      .i_valid(s_b_valid), .i_data(s_b), .o_ready(s_b_ready),
      .o_valid(m_b_valid), .o_data(m_b), .i_ready(m_b_ready)
   );
   axil_channel_slice #(.t_payload(axil_r_t)) u_r_slice (
      .i_csr_clk, .i_csr_rst_n,
      .i_valid(s_r_valid), .i_data(s_r), .o_ready(s_r_ready),
      .o_valid(m_r_valid), .o_data(m_r), .i_ready(m_r_ready)
   );

   csr_register_file u_regs (
      .i_csr_clk, .i_csr_rst_n,
      .i_aw_valid(s_aw_valid), .i_aw(s_aw), .o_aw_ready(s_aw_ready),
      .i_w_valid(s_w_valid), .i_w(s_w), .o_w_ready(s_w_ready),
      .o_b_valid(s_b_valid), .o_b(s_b), .i_b_ready(s_b_ready),
      .i_ar_valid(s_ar_valid), .i_ar(s_ar), .o_ar_ready(s_ar_ready),
      .o_r_valid(s_r_valid), .o_r(s_r), .i_r_ready(s_r_ready)
   );

endmodule

//--- verification/tb_indirect_csr.sv
// Testbench for the indirect CSR path, run with the sim.f file list and tb_indirect_csr as top
`timescale 1ns/1ps
`include "csr_bridge_macros.svh"

module tb_indirect_csr;
   import csr_bridge_pkg::*;

   localparam int          ACK_TIMEOUT = 200;   // Cycles
   localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

   typedef struct packed {
      csr_cmd_e               cmd;
      logic [`CSR_ADDR_W-1:0] addr;
      logic [`CSR_DATA_W-1:0] wdata;
      logic [`CSR_DATA_W-1:0] rdata;
      logic [1:0]             rresp;
      logic [1:0]             bresp;
      logic [7:0]             wr_txn;   // Register file handshakes seen
      logic [7:0]             rd_txn;
   } result_t;

   logic                   i_csr_clk;
   logic                   i_csr_rst_n;
   csr_cmd_e               i_csr_cmd;
   logic [`CSR_ADDR_W-1:0] i_csr_addr;
   logic [`CSR_DATA_W-1:0] i_csr_writedata;
   logic [`CSR_DATA_W-1:0] o_csr_readdata;
   logic                   o_csr_ack;
   logic [1:0]             o_csr_rresp;
   logic [1:0]             o_csr_bresp;

   logic [`CSR_DATA_W-1:0] model [`CSR_NUM_REGS];
   logic [31:0]            lfsr;
   result_t                results [$];
   int                     errors;
   int                     timeouts;
   int                     checks;
   int                     aw_count;
   int                     ar_count;

   indirect_csr_top uut (
      .i_csr_clk, .i_csr_rst_n,
      .i_csr_cmd, .i_csr_addr, .i_csr_writedata,
      .o_csr_readdata, .o_csr_ack, .o_csr_rresp, .o_csr_bresp
   );

   always #20 i_csr_clk = ~i_csr_clk;   // 40 ns period

   // Transactions as they reach the register file
   always @(posedge i_csr_clk) begin
      if (uut.s_aw_valid && uut.s_aw_ready) begin
         aw_count++;
      end
      if (uut.s_ar_valid && uut.s_ar_ready) begin
         ar_count++;
      end
   end

   // ---------------------------------------
   // Random source and reference model
   // ---------------------------------------
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   // Expected {data, resp}; a write updates the model
   function automatic logic [33:0] ref_access(input csr_cmd_e cmd,
                                              input logic [`CSR_ADDR_W-1:0] addr,
                                              input logic [`CSR_DATA_W-1:0] wdata);
      logic [`CSR_ADDR_W-3:0] word;
      logic [`CSR_DATA_W-1:0] data;
      logic [1:0]             resp;
      word = addr[`CSR_ADDR_W-1:2];
      if (word < `CSR_NUM_REGS) begin
         if (cmd == WRITE) begin
            model[word] = wdata;
         end
         data = model[word];
         resp = OKAY;
      end else begin
         data = '0;   // Nothing stored past the bank
         resp = SLVERR;
      end
      return {data, resp};
   endfunction

   task automatic report_error(input string msg);
      $display("** Error [%0t] %s", $time, msg);
      errors++;
   endtask

   task automatic check_result(input result_t res);
      logic [33:0] exp;
      exp = ref_access(res.cmd, res.addr, res.wdata);
      checks++;
      if (res.cmd == WRITE) begin
         assert (res.bresp == exp[1:0]) else
            report_error($sformatf("write 0x%05h bresp %0d, expected %0d",
                                   res.addr, res.bresp, exp[1:0]));
         assert (res.wr_txn == 1 && res.rd_txn == 0) else
            report_error($sformatf("write 0x%05h gave %0d writes and %0d reads",
                                   res.addr, res.wr_txn, res.rd_txn));
      end else begin
         assert (res.rdata == exp[33:2] && res.rresp == exp[1:0]) else
            report_error($sformatf("read 0x%05h got 0x%08h/%0d, expected 0x%08h/%0d",
                                   res.addr, res.rdata, res.rresp, exp[33:2], exp[1:0]));
         assert (res.rd_txn == 1 && res.wr_txn == 0) else
            report_error($sformatf("read 0x%05h gave %0d reads and %0d writes",
                                   res.addr, res.rd_txn, res.wr_txn));
      end
   endtask

   // Comparison of finished commands, in issue order
   always @(negedge i_csr_clk) begin
      while (results.size() != 0) begin
         check_result(results.pop_front());
      end
   end

   // ---------------------------------------
   // Host command
   // ---------------------------------------
   task automatic do_command(input csr_cmd_e cmd, input logic [`CSR_ADDR_W-1:0] addr,
                             input logic [`CSR_DATA_W-1:0] data, input int hold);
      result_t res;
      int      cycles;
      int      aw_start;
      int      ar_start;
      if (timeouts != 0) begin
         return;
      end
      aw_start        = aw_count;
      ar_start        = ar_count;
      i_csr_cmd       = cmd;
      i_csr_addr      = addr;
      i_csr_writedata = data;
      cycles          = 0;
      while (!o_csr_ack && cycles < ACK_TIMEOUT) begin
         @(negedge i_csr_clk);
         cycles++;
      end
      if (!o_csr_ack) begin
         $display("Timeout: %s command to address 0x%05h never got an acknowledge",
                  (cmd == WRITE) ? "WRITE" : "READ", addr);
         timeouts++;
         i_csr_cmd = NOOP;
         return;
      end
      res.cmd   = cmd;
      res.addr  = addr;
      res.wdata = data;
      res.rdata = o_csr_readdata;
      res.rresp = o_csr_rresp;
      res.bresp = o_csr_bresp;
      for (int i = 0; i < hold; i++) begin   // Command held past the acknowledge
         @(negedge i_csr_clk);
         assert (o_csr_ack) else
            report_error($sformatf("ack dropped while command to 0x%05h held", addr));
      end
      i_csr_cmd = NOOP;
      cycles    = 0;
      while (o_csr_ack && cycles < ACK_TIMEOUT) begin
         @(negedge i_csr_clk);
         cycles++;
      end
      if (o_csr_ack) begin
         $display("Timeout: acknowledge stayed high after NOOP at address 0x%05h", addr);
         timeouts++;
         return;
      end
      res.wr_txn = aw_count - aw_start;
      res.rd_txn = ar_count - ar_start;
      results.push_back(res);
   endtask

   // ---------------------------------------
   // Test sequence
   // ---------------------------------------
   initial begin
      csr_cmd_e               cmd;
      logic [`CSR_ADDR_W-1:0] addr;
      logic [`CSR_DATA_W-1:0] data;
      int                     cycles;
      i_csr_clk       = 1'b0;
      i_csr_rst_n     = 1'b0;
      i_csr_cmd       = NOOP;
      i_csr_addr      = '0;
      i_csr_writedata = '0;
      lfsr            = 32'h15bb;
      errors          = 0;
      timeouts        = 0;
      checks          = 0;
      aw_count        = 0;
      ar_count        = 0;
      for (int i = 0; i < `CSR_NUM_REGS; i++) begin
         model[i] = '0;
      end
      repeat (16) @(posedge i_csr_clk);
      @(negedge i_csr_clk);
      i_csr_rst_n = 1'b1;
      @(negedge i_csr_clk);
      assert (!o_csr_ack && o_csr_readdata == 0 && o_csr_rresp == 0 && o_csr_bresp == 0)
         else report_error("outputs not zero after reset");

      for (int i = 0; i < `CSR_NUM_REGS; i++) begin   // Bank starts cleared
         do_command(READ, i * 4, '0, 0);
      end
      for (int i = 0; i < 4; i++) begin
         addr = take_bits(6);
         do_command(WRITE, addr, take_bits(32), 0);
         do_command(READ, addr, '0, 0);
      end
      do_command(WRITE, 19'h00014, take_bits(32), 8);   // Long hold, one update only
      do_command(READ, 19'h00014, '0, 6);

      // Past the bank, index bits alias register 1
      do_command(WRITE, 19'h00044, 32'hdead_beef, 0);
      do_command(READ, 19'h00044, '0, 0);
      do_command(READ, 19'h7fffc, '0, 0);
      for (int i = 0; i < `CSR_NUM_REGS; i++) begin
         do_command(READ, i * 4, '0, 0);
      end

      for (int n = 0; n < 200 && timeouts == 0; n++) begin
         cmd  = take_bits(1) ? WRITE : READ;
         addr = (take_bits(2) == 0) ? take_bits(19) | 19'h00040 : take_bits(6);
         data = take_bits(32);
         do_command(cmd, addr, data, take_bits(2));
         repeat (take_bits(2)) @(negedge i_csr_clk);   // Idle gap
      end

      cycles = 0;
      while (results.size() != 0 && cycles < 10) begin
         @(negedge i_csr_clk);
         cycles++;
      end
      if (results.size() != 0) begin
         $display("Comparison process left %0d results unchecked", results.size());
         timeouts++;
      end
      $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- sim.f
+incdir+verilog
verilog/csr_bridge_pkg.sv
verilog/indirect_csr_master.sv
verilog/axil_channel_slice.sv
verilog/csr_register_file.sv
verilog/indirect_csr_top.sv
verification/tb_indirect_csr.sv
